//--- logic/mems_settings.svh
`ifndef MEMS_SETTINGS_SVH
`define MEMS_SETTINGS_SVH

// Clocks per UART bit, kept small for simulation
`define MEMS_UART_DIV 8

// Clocks per SPI half period
`define MEMS_SPI_DIV 4

// Clocks per fclk half period
`define MEMS_FCLK_DIV 64

// SPI queue depth, also the starting credit count
`define MEMS_SPI_DEPTH 4

// Acknowledge FIFO depth
`define MEMS_ACK_DEPTH 4

// Bits per MEMS driver word
`define MEMS_WORD_W 24

`endif

//--- logic/mems_pkg.sv
package mems_pkg;

  // Command nibble of a driver word
  typedef enum logic [3:0] {
    WRITE  = 4'd0,
    UPDATE = 4'd1, // Latch written values
    LINE   = 4'd2, // Toggles line_led
    FRAME  = 4'd3  // Toggles frame_led
  } mems_cmd_e;

  // One driver word, sent MSB first on the wire
  typedef struct packed {
    logic [3:0]  cmd;
    logic [3:0]  chan;
    logic [15:0] value;
  } mems_word_t;

  typedef logic [7:0] uart_byte_t; // Serial byte
  typedef logic [7:0] ack_t;       // XOR of the three word bytes

endpackage

//--- logic/word_fifo.sv
`timescale 1ns/1ps

module word_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     push,
  input  payload_t din,
  input  logic     pop,
  output payload_t dout,
  output logic     empty,
  output logic     full
);

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1; // Pointer width
  localparam int CW = $clog2(DEPTH + 1);               // Occupancy width

  payload_t      mem [DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          do_push;
  logic          do_pop;

  assign do_push = push && !full;  // Overflow ignored
  assign do_pop  = pop && !empty;  // Underflow ignored
  assign empty   = (count == '0);
  assign full    = (count == CW'(DEPTH));
  assign dout    = mem[rd_ptr];    // Head visible while not empty

  // Storage
  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= din;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1; // Wrap
      if (do_pop)  rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // Both or neither
      endcase
    end
  end

endmodule

//--- logic/uart_rx.sv
`timescale 1ns/1ps
`include "mems_settings.svh"

module uart_rx (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 rx,
  output mems_pkg::uart_byte_t rx_byte,
  output logic                 rx_valid
);

  localparam int CW = $clog2(`MEMS_UART_DIV);
  localparam logic [CW-1:0] LAST = CW'(`MEMS_UART_DIV - 1);     // Full bit
  localparam logic [CW-1:0] HALF = CW'(`MEMS_UART_DIV / 2 - 1); // Half bit

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

  rx_state_e     state;
  logic [1:0]    rx_sync;  // Two flop synchroniser
  logic [CW-1:0] cnt;
  logic [2:0]    bit_cnt;
  logic          rx_s;

  assign rx_s = rx_sync[1];

  always_ff @(posedge clk) begin
    if (rst) begin
      rx_sync  <= 2'b11; // Line idles high
      state    <= RX_IDLE;
      cnt      <= '0;
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_sync  <= {rx_sync[0], rx};
      rx_valid <= 1'b0;
      case (state)
        RX_IDLE: begin
          cnt <= '0;
          if (!rx_s) state <= RX_START; // Start edge
        end
        RX_START: begin
          if (cnt == HALF) begin
            cnt     <= '0;
            bit_cnt <= '0;
            state   <= rx_s ? RX_IDLE : RX_DATA; // Glitch, not a start bit
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        RX_DATA: begin
          if (cnt == LAST) begin
            cnt     <= '0;
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) state <= RX_STOP;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        RX_STOP: begin
          if (cnt == LAST) begin
            state    <= RX_IDLE;
            rx_valid <= rx_s; // Bad stop bit drops the byte
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clk) begin
    if (state == RX_DATA && cnt == LAST) rx_byte <= {rx_s, rx_byte[7:1]};
  end

endmodule

//--- logic/uart_tx.sv
`timescale 1ns/1ps
`include "mems_settings.svh"

module uart_tx (
  input  logic           clk,
  input  logic           rst,
  input  mems_pkg::ack_t ack_byte,
  input  logic           ack_valid,
  input  logic           tx_block,
  output logic           ack_take,
  output logic           tx
);

  localparam int CW = $clog2(`MEMS_UART_DIV);
  localparam logic [CW-1:0] LAST = CW'(`MEMS_UART_DIV - 1);

  typedef enum logic {TX_IDLE, TX_SHIFT} tx_state_e;

  tx_state_e     state;
  logic [CW-1:0] cnt;
  logic [3:0]    bit_cnt;  // Bits already on the line
  logic [8:0]    shreg;    // Data bits then stop

  // Load only when idle and host not blocking
  assign ack_take = (state == TX_IDLE) && ack_valid && !tx_block;

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= TX_IDLE;
      tx      <= 1'b1;
      cnt     <= '0;
      bit_cnt <= '0;
    end else begin
      case (state)
        TX_IDLE: begin
          if (ack_take) begin
            tx      <= 1'b0; // Start bit
            cnt     <= '0;
            bit_cnt <= '0;
            state   <= TX_SHIFT;
          end
        end
        TX_SHIFT: begin
          if (cnt == LAST) begin
            cnt <= '0;
            if (bit_cnt == 4'd9) begin
              state <= TX_IDLE; // Stop bit done, tx already high
            end else begin
              tx      <= shreg[0];
              bit_cnt <= bit_cnt + 1'b1;
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (ack_take) begin
      shreg <= {1'b1, ack_byte};
    end else if (state == TX_SHIFT && cnt == LAST) begin
      shreg <= {1'b1, shreg[8:1]}; // LSB first
    end
  end

endmodule

//--- logic/mems_control.sv
`timescale 1ns/1ps
`include "mems_settings.svh"

module mems_control (
  input  logic                 clk,
  input  logic                 rst,
  input  mems_pkg::uart_byte_t rx_byte,
  input  logic                 rx_valid,
  input  logic                 credit,
  input  logic                 ack_take,
  output mems_pkg::mems_word_t word,
  output logic                 word_push,
  output logic                 cts,
  output mems_pkg::ack_t       ack_byte,
  output logic                 ack_valid,
  output logic                 line_led,
  output logic                 frame_led,
  output logic                 fclk
);

  localparam int CRW = $clog2(`MEMS_SPI_DEPTH + 1);
  localparam int FW  = $clog2(`MEMS_FCLK_DIV);

  logic [1:0]     idx;      // Byte position in word
  logic [23:0]    asm_q;    // MSB byte arrives first
  mems_pkg::ack_t xor_q;    // Running XOR of word bytes
  logic           pending;  // Full word waiting for release
  logic           accept;
  logic [CRW-1:0] cred;
  logic           ack_empty;
  logic           ack_full;
  logic [FW-1:0]  fcnt;

  assign word      = mems_pkg::mems_word_t'(asm_q);
  assign cts       = (cred != '0);
  assign word_push = pending && cts && !ack_full; // Needs credit and ack room
  assign accept    = rx_valid && (!pending || word_push);
  assign ack_valid = !ack_empty;

  // Byte assembly
  always_ff @(posedge clk) begin
    if (rst) begin
      idx     <= '0;
      pending <= 1'b0;
    end else begin
      if (word_push) pending <= 1'b0;
      if (accept) begin
        if (idx == 2'd2) begin
          idx     <= '0;
          pending <= 1'b1; // Released next cycle at the earliest
        end else begin
          idx <= idx + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      asm_q <= {asm_q[15:0], rx_byte};
      xor_q <= (idx == 2'd0) ? rx_byte : (xor_q ^ rx_byte);
    end
  end

  // Credits toward the SPI queue
  always_ff @(posedge clk) begin
    if (rst) begin
      cred <= CRW'(`MEMS_SPI_DEPTH);
    end else begin
      case ({word_push, credit})
        2'b10:   cred <= cred - 1'b1;
        2'b01:   cred <= cred + 1'b1;
        default: cred <= cred; // Both cancel
      endcase
    end
  end

  // LED toggles on release
  always_ff @(posedge clk) begin
    if (rst) begin
      line_led  <= 1'b0;
      frame_led <= 1'b0;
    end else if (word_push) begin
      if (word.cmd == mems_pkg::LINE)  line_led  <= ~line_led;
      if (word.cmd == mems_pkg::FRAME) frame_led <= ~frame_led;
    end
  end

  // Free running frame clock
  always_ff @(posedge clk) begin
    if (rst) begin
      fcnt <= '0;
      fclk <= 1'b0;
    end else if (fcnt == FW'(`MEMS_FCLK_DIV - 1)) begin
      fcnt <= '0;
      fclk <= ~fclk;
    end else begin
      fcnt <= fcnt + 1'b1;
    end
  end

  word_fifo #(
    .payload_t (mems_pkg::ack_t),
    .DEPTH     (`MEMS_ACK_DEPTH)
  ) ack_fifo_i (
    .clk   (clk),
    .rst   (rst),
    .push  (word_push), // Ack queued with the word
    .din   (xor_q),
    .pop   (ack_take),
    .dout  (ack_byte),
    .empty (ack_empty),
    .full  (ack_full)
  );

endmodule

//--- logic/mems_spi.sv
`timescale 1ns/1ps
`include "mems_settings.svh"

module mems_spi (
  input  logic                 clk,
  input  logic                 rst,
  input  mems_pkg::mems_word_t word,
  input  logic                 word_push,
  output logic                 credit,
  output logic                 spi_cs,
  output logic                 spi_sck,
  output logic                 spi_mosi
);

  localparam int DW = $clog2(`MEMS_SPI_DIV);
  localparam int BW = $clog2(`MEMS_WORD_W);

  typedef enum logic [1:0] {SPI_IDLE, SPI_SHIFT, SPI_TAIL, SPI_GAP} spi_state_e;

  spi_state_e           state;
  mems_pkg::mems_word_t head;
  logic                 q_empty;
  logic                 pop;
  logic [DW-1:0]        div_cnt;
  logic                 tick;    // Half period boundary
  logic [BW-1:0]        bit_cnt;
  logic [`MEMS_WORD_W-1:0] shreg;

  assign pop    = (state == SPI_IDLE) && !q_empty;
  assign credit = pop; // One credit back per popped word
  assign tick   = (div_cnt == DW'(`MEMS_SPI_DIV - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= SPI_IDLE;
      spi_cs   <= 1'b1;
      spi_sck  <= 1'b0;
      spi_mosi <= 1'b0;
      div_cnt  <= '0;
      bit_cnt  <= '0;
    end else begin
      div_cnt <= (state == SPI_IDLE || tick) ? '0 : div_cnt + 1'b1;
      case (state)
        SPI_IDLE: begin
          if (pop) begin
            spi_cs   <= 1'b0;
            spi_mosi <= head[`MEMS_WORD_W-1]; // MSB ready before first rise
            bit_cnt  <= '0;
            state    <= SPI_SHIFT;
          end
        end
        SPI_SHIFT: begin
          if (tick) begin
            spi_sck <= ~spi_sck;
            if (spi_sck) begin // Falling edge
              if (bit_cnt == BW'(`MEMS_WORD_W - 1)) begin
                state <= SPI_TAIL;
              end else begin
                spi_mosi <= shreg[`MEMS_WORD_W-1];
                bit_cnt  <= bit_cnt + 1'b1;
              end
            end
          end
        end
        SPI_TAIL: begin
          if (tick) begin
            spi_cs <= 1'b1; // Half period after last fall
            state  <= SPI_GAP;
          end
        end
        SPI_GAP: begin
          if (tick) state <= SPI_IDLE; // Minimum cs high time
        end
        default: state <= SPI_IDLE;
      endcase
    end
  end

  // Remaining bits, next one at the top
  always_ff @(posedge clk) begin
    if (pop) begin
      shreg <= {head[`MEMS_WORD_W-2:0], 1'b0};
    end else if (state == SPI_SHIFT && tick && spi_sck) begin
      shreg <= {shreg[`MEMS_WORD_W-2:0], 1'b0};
    end
  end

  // Credits keep this queue from overflowing
  word_fifo #(
    .payload_t (mems_pkg::mems_word_t),
    .DEPTH     (`MEMS_SPI_DEPTH)
  ) word_fifo_i (
    .clk   (clk),
    .rst   (rst),
    .push  (word_push),
    .din   (word),
    .pop   (pop),
    .dout  (head),
    .empty (q_empty),
    .full  ()
  );

endmodule

//--- logic/mems_top.sv
`timescale 1ns/1ps

module mems_top (
  input  logic clk,
  input  logic rst,
  input  logic rx,        // From host, idle high
  output logic tx,        // Acks to host
  input  logic tx_block,  // Host receive buffer full
  output logic cts,       // Host may send
  output logic spi_cs,    // Active low
  output logic spi_sck,
  output logic spi_mosi,
  output logic fclk,      // Mirror filter clock
  output logic line_led,
  output logic frame_led
);

  mems_pkg::uart_byte_t rx_byte;
  logic                 rx_valid;
  mems_pkg::mems_word_t word;
  logic                 word_push;
  logic                 credit;
  mems_pkg::ack_t       ack_byte;
  logic                 ack_valid;
  logic                 ack_take;

  uart_rx uart_rx_i (
    .clk      (clk),
    .rst      (rst),
    .rx       (rx),
    .rx_byte  (rx_byte),
    .rx_valid (rx_valid)
  );

  uart_tx uart_tx_i (
    .clk       (clk),
    .rst       (rst),
    .ack_byte  (ack_byte),
    .ack_valid (ack_valid),
    .tx_block  (tx_block),
    .ack_take  (ack_take),
    .tx        (tx)
  );

  mems_control mems_control_i (
    .clk       (clk),
    .rst       (rst),
    .rx_byte   (rx_byte),
    .rx_valid  (rx_valid),
    .credit    (credit),
    .ack_take  (ack_take),
    .word      (word),
    .word_push (word_push),
    .cts       (cts),
    .ack_byte  (ack_byte),
    .ack_valid (ack_valid),
    .line_led  (line_led),
    .frame_led (frame_led),
    .fclk      (fclk)
  );

  mems_spi mems_spi_i (
    .clk       (clk),
    .rst       (rst),
    .word      (word),
    .word_push (word_push),
    .credit    (credit),
    .spi_cs    (spi_cs),
    .spi_sck   (spi_sck),
    .spi_mosi  (spi_mosi)
  );

endmodule

//--- dv/mems_top_tb.sv
`timescale 1ns/1ps
`include "mems_settings.svh"

module mems_top_tb;

  localparam int N        = 13;              // Table entries
  localparam int BIT_CLKS = `MEMS_UART_DIV;
  localparam int FCLK_WIN = 16 * `MEMS_FCLK_DIV; // Window for 16 fclk edges
  // Twice 40 UART bits plus 60 SPI half periods per word
  localparam longint LIMIT_CLKS = N * (40 * `MEMS_UART_DIV + 60 * `MEMS_SPI_DIV) * 2 + 200;

  typedef struct packed {
    mems_pkg::mems_word_t word;
    logic                 blk;   // Random tx_block bursts
    logic                 burst; // Back to back bytes without ack wait
  } stim_t;

  logic clk;
  logic rst;
  logic rx;
  logic tx_block;
  logic tx;
  logic cts;
  logic spi_cs;
  logic spi_sck;
  logic spi_mosi;
  logic fclk;
  logic line_led;
  logic frame_led;

  stim_t                tbl [N];
  mems_pkg::mems_word_t spi_exp [$]; // Scoreboard queues
  mems_pkg::ack_t       ack_exp [$];
  int   errors     = 0;
  int   words_sent = 0;
  int   spi_got    = 0;
  int   spi_starts = 0; // cs low windows opened
  int   acks_got   = 0;
  int   cts_falls  = 0;
  int   spi_bits   = 0;
  logic [23:0] spi_sr;
  logic in_word    = 1'b0; // Inside a cs low window
  logic blk_en     = 1'b0;
  logic fclk_done  = 1'b0;
  logic line_par   = 1'b0; // Expected LED states
  logic frame_par  = 1'b0;

  mems_top mems_top_i (
    .clk (clk), .rst (rst), .rx (rx), .tx (tx), .tx_block (tx_block), .cts (cts),
    .spi_cs (spi_cs), .spi_sck (spi_sck), .spi_mosi (spi_mosi), .fclk (fclk),
    .line_led (line_led), .frame_led (frame_led)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    errors++;
    $display("FAILED %0t ns %s expected %0h got %0h", $time, name, exp, got);
  endtask

  // One 8N1 byte from the host LSB first
  task automatic send_byte(input logic [7:0] b, input logic fast);
    int gap;
    gap = fast ? 0 : $urandom_range(2 * BIT_CLKS, 0);
    repeat (gap) @(negedge clk);
    rx = 1'b0; // Start
    repeat (BIT_CLKS) @(negedge clk);
    for (int i = 0; i < 8; i++) begin
      rx = b[i];
      repeat (BIT_CLKS) @(negedge clk);
    end
    rx = 1'b1; // Stop
    repeat (BIT_CLKS) @(negedge clk);
  endtask

  task automatic send_word(input stim_t s);
    logic [23:0] w;
    w = s.word;
    // Host honours cts and keeps ack FIFO from filling
    while (!(cts && (words_sent - acks_got) < `MEMS_ACK_DEPTH)) @(negedge clk);
    spi_exp.push_back(s.word);
    ack_exp.push_back(w[23:16] ^ w[15:8] ^ w[7:0]);
    if (s.word.cmd == mems_pkg::LINE)  line_par  = ~line_par;
    if (s.word.cmd == mems_pkg::FRAME) frame_par = ~frame_par;
    send_byte(w[23:16], s.burst); // MSB first
    send_byte(w[15:8], s.burst);
    send_byte(w[7:0], s.burst);
    words_sent++;
  endtask

  // Random host blocking
  initial begin
    int hold;
    hold = 0;
    tx_block = 1'b0;
    forever begin
      @(negedge clk);
      if (!blk_en) begin
        tx_block = 1'b0;
      end else if (hold == 0) begin
        tx_block = ~tx_block;
        hold = $urandom_range(120, 10);
      end else begin
        hold--;
      end
    end
  end

  // SPI monitor
  always @(negedge spi_cs) begin
    in_word  = 1'b1;
    spi_bits = 0;
    spi_starts++;
  end

  always @(posedge spi_sck) begin
    if (in_word) begin
      spi_sr = {spi_sr[22:0], spi_mosi}; // MSB first
      spi_bits++;
    end
  end

  always @(posedge spi_cs) begin
    if (in_word) begin
      in_word = 1'b0;
      spi_got++;
      assert (spi_bits == 24) else report_mismatch("spi_sck rises per word", 24, spi_bits);
      assert (spi_exp.size() != 0) else begin
        errors++;
        $display("SPI word %h arrived with none outstanding", spi_sr);
      end
      if (spi_exp.size() != 0) begin
        assert (spi_sr == spi_exp[0])
          else report_mismatch("spi_mosi word", 32'(spi_exp[0]), 32'(spi_sr));
        void'(spi_exp.pop_front());
      end
    end
  end

  // Ack monitor sampling tx near mid bit
  initial begin
    logic [7:0] b;
    forever begin
      @(negedge tx);
      repeat (BIT_CLKS / 2) @(negedge clk);
      assert (tx == 1'b0) else begin
        errors++;
        $display("Start bit on tx shorter than half a bit at %0t ns", $time);
      end
      for (int i = 0; i < 8; i++) begin
        repeat (BIT_CLKS) @(negedge clk);
        b[i] = tx;
      end
      repeat (BIT_CLKS) @(negedge clk);
      assert (tx == 1'b1) else begin
        errors++;
        $display("Stop bit missing on tx at %0t ns", $time);
      end
      assert (ack_exp.size() != 0) else begin
        errors++;
        $display("Ack byte %h arrived with no word outstanding", b);
      end
      if (ack_exp.size() != 0) begin
        assert (b == ack_exp[0]) else report_mismatch("tx ack byte", 32'(ack_exp[0]), 32'(b));
        void'(ack_exp.pop_front());
      end
      acks_got++;
    end
  end

  // Edge count of fclk over a fixed window
  initial begin
    int   edges;
    logic prev;
    edges = 0;
    @(negedge rst);
    @(negedge clk);
    prev = fclk;
    repeat (FCLK_WIN) begin
      @(negedge clk);
      if (fclk !== prev) edges++;
      prev = fclk;
    end
    assert (edges >= 15 && edges <= 17) else report_mismatch("fclk edges", 16, edges);
    fclk_done = 1'b1;
  end

  // cts drops only once the SPI queue holds a full set of words
  always @(negedge cts) begin
    if (!rst) begin
      cts_falls++;
      assert (words_sent - spi_starts >= `MEMS_SPI_DEPTH) else begin
        errors++;
        $display("cts fell at %0t ns with only %0d words waiting for SPI", $time,
                 words_sent - spi_starts);
      end
    end
  end

  initial begin
    #(LIMIT_CLKS * 40);
    $display("Timeout after %0d clock cycles, %0d of %0d SPI words and %0d acks seen",
             LIMIT_CLKS, spi_got, N, acks_got);
    $display("Test failed");
    $finish;
  end

  initial begin
    void'($urandom(53223));
    rst  = 1'b1;
    rx   = 1'b1; // Idle line
    tbl = '{
      {24'h011234, 1'b0, 1'b0}, // WRITE
      {24'h100000, 1'b0, 1'b0}, // UPDATE
      {24'h2000AA, 1'b0, 1'b0}, // LINE
      {24'h02BEEF, 1'b1, 1'b0},
      {24'h300001, 1'b1, 1'b0}, // FRAME
      {24'h0FFFFF, 1'b1, 1'b0},
      {24'h235A5A, 1'b1, 1'b0}, // LINE
      {24'h048001, 1'b0, 1'b1}, // Burst from here
      {24'h057FFE, 1'b0, 1'b1},
      {24'h36C3C3, 1'b1, 1'b1},
      {24'h270F0F, 1'b1, 1'b1},
      {24'h08A5A5, 1'b0, 1'b1},
      {24'h190102, 1'b0, 1'b1}
    };
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    assert (spi_cs === 1'b1) else report_mismatch("spi_cs", 1, 32'(spi_cs));
    assert (tx === 1'b1) else report_mismatch("tx", 1, 32'(tx));
    assert (cts === 1'b1) else report_mismatch("cts", 1, 32'(cts));
    assert (line_led === 1'b0) else report_mismatch("line_led", 0, 32'(line_led));
    assert (frame_led === 1'b0) else report_mismatch("frame_led", 0, 32'(frame_led));
    assert (fclk === 1'b0) else report_mismatch("fclk", 0, 32'(fclk));

    for (int i = 0; i < N; i++) begin
      blk_en = tbl[i].blk;
      send_word(tbl[i]);
      if (!tbl[i].burst) begin
        while (acks_got != words_sent) @(negedge clk); // This word's ack
        assert (line_led === line_par)
          else report_mismatch("line_led", 32'(line_par), 32'(line_led));
        assert (frame_led === frame_par)
          else report_mismatch("frame_led", 32'(frame_par), 32'(frame_led));
      end
    end
    blk_en = 1'b0;

    // Drain and settle to catch stray words
    while (spi_got < N || acks_got < N || !fclk_done) @(negedge clk);
    repeat (100) @(negedge clk);
    assert (spi_got == N) else report_mismatch("SPI word count", N, spi_got);
    assert (acks_got == N) else report_mismatch("ack byte count", N, acks_got);
    assert (cts === 1'b1) else report_mismatch("cts after drain", 1, 32'(cts));
    assert (line_led === line_par)
      else report_mismatch("line_led", 32'(line_par), 32'(line_led));
    assert (frame_led === frame_par)
      else report_mismatch("frame_led", 32'(frame_par), 32'(frame_led));

    $display("Errors: %0d, SPI words: %0d of %0d, acks: %0d of %0d, cts falls: %0d",
             errors, spi_got, N, acks_got, N, cts_falls);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+logic
logic/mems_pkg.sv
logic/word_fifo.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/mems_control.sv
logic/mems_spi.sv
logic/mems_top.sv
dv/mems_top_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the MEMS bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module mems_top_tb \
  --Mdir obj_dir -o mems_top_tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/mems_top_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" "$LOG"; then
  exit 1
fi
exit 0
